// ==== source/link_pkg.sv ====
// --------------------------------------
// Shared widths, structs and the register map of the word link
// Counter width is fixed at 16 bits and the register map fits in a 4-bit address
// --------------------------------------
`default_nettype none

package link_pkg;

  // --------------------------------------
  // Link geometry
  // --------------------------------------
  localparam int link_data_width  = 32;
  // Register stages in the delay line between transmit and receive
  localparam int link_num_stages  = 3;
  localparam int link_count_width = 16;

  // --------------------------------------
  // Wishbone bus and register map
  // --------------------------------------
  localparam int wb_addr_width = 4;
  localparam int wb_data_width = 32;

  localparam logic [wb_addr_width-1:0] reg_ctrl_addr   = 4'h0;
  localparam logic [wb_addr_width-1:0] reg_words_addr  = 4'h4;
  localparam logic [wb_addr_width-1:0] reg_errors_addr = 4'h8;

  // One word on the link with its even parity bit in the LSB
  typedef struct packed {
    logic [link_data_width-1:0] data;
    logic                       parity;
  } link_payload_t;

  // Field order follows the control register so enable lands on bit 0
  typedef struct packed {
    logic inject_parity_error;
    logic enable;
  } link_ctrl_t;

  typedef struct packed {
    logic [link_count_width-1:0] word_count;
    logic [link_count_width-1:0] parity_error_count;
  } link_stat_t;

  // Single-cycle pulses from the register block to the receive counters
  typedef struct packed {
    logic clear_words;
    logic clear_errors;
  } link_clear_t;

endpackage

`default_nettype wire

// ==== source/link_regs.sv ====
// --------------------------------------
// Wishbone classic slave for link control and the receive counters
// Ack comes one cycle after cyc and stb, and unmapped addresses read zero
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module link_regs
  import link_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // Wishbone classic slave port
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  logic [wb_addr_width-1:0] adr,
  input  logic [wb_data_width-1:0] dat_i,
  output logic [wb_data_width-1:0] dat_o,
  output logic                     ack,
  // Link side
  output link_ctrl_t               ctrl,
  output link_clear_t              clear,
  input  link_stat_t               stat
);

  // The cycle before ack is the one and only accepted beat of a transfer
  logic                     access;
  logic                     wr_access;
  logic                     rd_access;
  logic [wb_data_width-1:0] rd_data;

  // Blocking on ack keeps a held strobe from being acknowledged twice
  assign access    = cyc & stb & ~ack;
  assign wr_access = access & we;
  assign rd_access = access & ~we;

  // --------------------------------------
  // Handshake
  // --------------------------------------

  // Ack is high for exactly one cycle per transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  // --------------------------------------
  // Write side
  // --------------------------------------

  // Control register updates on the edge that raises ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl <= '0;
    end else if (wr_access && (adr == reg_ctrl_addr)) begin
      // Only the low bits are implemented, the rest of dat_i is ignored
      ctrl <= link_ctrl_t'(dat_i[$bits(link_ctrl_t)-1:0]);
    end
  end

  // Clear pulses are decoded in the accepted beat
  // The counters therefore drop to zero on the same edge that raises ack
  always_comb begin
    clear              = '0;
    clear.clear_words  = wr_access && (adr == reg_words_addr);
    clear.clear_errors = wr_access && (adr == reg_errors_addr);
  end

  // --------------------------------------
  // Read side
  // --------------------------------------

  // Counters are zero-extended to the bus width
  always_comb begin
    rd_data = '0;
    case (adr)
      reg_ctrl_addr: begin
        rd_data[$bits(link_ctrl_t)-1:0] = ctrl;
      end
      reg_words_addr: begin
        rd_data[link_count_width-1:0] = stat.word_count;
      end
      reg_errors_addr: begin
        rd_data[link_count_width-1:0] = stat.parity_error_count;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // Read data is captured with ack and holds until the next read
  always_ff @(posedge clk) begin
    if (rd_access) begin
      dat_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/link_tx.sv ====
// --------------------------------------
// Transmit stage, launches valid_next one cycle ahead of the payload
// in_ready follows the enable bit directly
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module link_tx
  import link_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  link_ctrl_t                 ctrl,
  // Input stream
  input  logic                       in_valid,
  input  logic [link_data_width-1:0] in_data,
  output logic                       in_ready,
  // Link launch
  output logic                       payload_valid_next,
  output link_payload_t              payload
);

  logic                       accept;
  logic [link_data_width-1:0] word_q;
  logic                       inject_q;

  assign in_ready = ctrl.enable;
  assign accept   = in_valid & in_ready;

  // Strobe goes out on the accepting edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      payload_valid_next <= 1'b0;
    end else begin
      payload_valid_next <= accept;
    end
  end

  // Hold the word and the inject request that were current at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      word_q   <= in_data;
      inject_q <= ctrl.inject_parity_error;
    end
  end

  // Payload follows one edge later, loaded only under the strobe
  // Even parity, so data and parity XOR to zero unless an error is injected
  always_ff @(posedge clk) begin
    if (payload_valid_next) begin
      payload.data   <= word_q;
      payload.parity <= (^word_q) ^ inject_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/link_delay_valid_next.sv ====
// --------------------------------------
// Delay line for a valid_next strobe and its payload, any payload type
// Payload registers have no reset, so out is undefined until the first word
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module link_delay_valid_next #(
  parameter int  num_stages   = 0,
  parameter type payload_type = logic
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid_next,
  input  payload_type in,
  output logic        out_valid_next,
  output payload_type out
);

  if (num_stages == 0) begin : gen_passthru
    // No registers at all, clock and reset stay unconnected inside
    assign out_valid_next = in_valid_next;
    assign out            = in;
  end else begin : gen_stages
    // Entry i is the strobe and payload after stage i+1
    logic [num_stages-1:0] vn_q;
    payload_type           data_q [num_stages];

    // The strobe chain is reset so nothing looks valid after reset
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vn_q <= '0;
      end else begin
        vn_q[0] <= in_valid_next;
        for (int i = 1; i < num_stages; i++) begin
          vn_q[i] <= vn_q[i-1];
        end
      end
    end

    // A stage's own strobe marks the cycle in which the previous stage holds
    // valid data, so the wide load happens one cycle after the strobe moved
    always_ff @(posedge clk) begin
      if (vn_q[0]) begin
        data_q[0] <= in;
      end
      for (int i = 1; i < num_stages; i++) begin
        if (vn_q[i]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    assign out_valid_next = vn_q[num_stages-1];
    assign out            = data_q[num_stages-1];
  end

endmodule

`default_nettype wire

// ==== source/link_rx.sv ====
// --------------------------------------
// Receive stage with parity check and saturating word and error counters
// The sink has no ready, every delivered word must be taken
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module link_rx
  import link_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Link arrival
  input  logic                       payload_valid_next,
  input  link_payload_t              payload,
  // Register block side
  input  link_clear_t                clear,
  output link_stat_t                 stat,
  // Output stream
  output logic                       out_valid,
  output logic [link_data_width-1:0] out_data
);

  // High in the cycle where payload holds the announced word
  logic data_valid;
  logic parity_bad;

  // Even parity over data and parity bit must come out zero
  assign parity_bad = ^payload;

  // --------------------------------------
  // Output path
  // --------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      data_valid <= payload_valid_next;
      out_valid  <= data_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (data_valid) begin
      out_data <= payload.data;
    end
  end

  // --------------------------------------
  // Counters
  // --------------------------------------

  // Both counters move on the edge that raises out_valid
  // A clear wins over an increment in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stat <= '0;
    end else begin
      if (clear.clear_words) begin
        stat.word_count <= '0;
      end else if (data_valid && (stat.word_count != '1)) begin
        stat.word_count <= stat.word_count + 1'b1;
      end
      if (clear.clear_errors) begin
        stat.parity_error_count <= '0;
      end else if (data_valid && parity_bad && (stat.parity_error_count != '1)) begin
        stat.parity_error_count <= stat.parity_error_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/link_top.sv ====
// --------------------------------------
// Top of the retimed word link with its Wishbone register block
// Latency from acceptance to out_valid is link_num_stages + 2 cycles
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module link_top
  import link_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Wishbone classic slave port
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [wb_addr_width-1:0]   adr,
  input  logic [wb_data_width-1:0]   dat_i,
  output logic [wb_data_width-1:0]   dat_o,
  output logic                       ack,
  // Input stream
  input  logic                       in_valid,
  input  logic [link_data_width-1:0] in_data,
  output logic                       in_ready,
  // Output stream, no back-pressure
  output logic                       out_valid,
  output logic [link_data_width-1:0] out_data
);

  link_ctrl_t    ctrl;
  link_clear_t   clear;
  link_stat_t    stat;

  // Launch side of the long wire
  logic          tx_valid_next;
  link_payload_t tx_payload;
  // Landing side after the delay line
  logic          rx_valid_next;
  link_payload_t rx_payload;

  link_regs u_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack   (ack),
    .ctrl  (ctrl),
    .clear (clear),
    .stat  (stat)
  );

  link_tx u_tx (
    .clk                (clk),
    .rst_n              (rst_n),
    .ctrl               (ctrl),
    .in_valid           (in_valid),
    .in_data            (in_data),
    .in_ready           (in_ready),
    .payload_valid_next (tx_valid_next),
    .payload            (tx_payload)
  );

  link_delay_valid_next #(
    .num_stages   (link_num_stages),
    .payload_type (link_payload_t)
  ) u_delay (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_next  (tx_valid_next),
    .in             (tx_payload),
    .out_valid_next (rx_valid_next),
    .out            (rx_payload)
  );

  link_rx u_rx (
    .clk                (clk),
    .rst_n              (rst_n),
    .payload_valid_next (rx_valid_next),
    .payload            (rx_payload),
    .clear              (clear),
    .stat               (stat),
    .out_valid          (out_valid),
    .out_data           (out_data)
  );

endmodule

`default_nettype wire

// ==== bench/link_tb.sv ====
// --------------------------------------
// Testbench for link_top with a queue model of the link
// Expects a fixed latency of 5 cycles and a sink without back-pressure
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module link_tb
  import link_pkg::*;
();

  // --------------------------------------
  // Model types and limits
  // --------------------------------------

  // One word in flight, with the cycle of its accepting edge
  typedef struct packed {
    logic [link_data_width-1:0] data;
    int                         cycle;
    logic                       inject;
  } expect_t;

  localparam int wb_timeout    = 20;
  localparam int in_timeout    = 20;
  localparam int drain_timeout = 40;
  localparam int link_latency  = 5;

  logic                       clk;
  logic                       rst_n;
  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [wb_addr_width-1:0]   adr;
  logic [wb_data_width-1:0]   dat_i;
  logic [wb_data_width-1:0]   dat_o;
  logic                       ack;
  logic                       in_valid;
  logic [link_data_width-1:0] in_data;
  logic                       in_ready;
  logic                       out_valid;
  logic [link_data_width-1:0] out_data;

  expect_t     expect_q[$];
  int          error_count    = 0;
  int          cycle          = 0;
  int          accepted_count = 0;
  int          injected_count = 0;
  logic        model_inject   = 1'b0;

  link_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_i     (dat_i),
    .dat_o     (dat_o),
    .ack       (ack),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------
  // Helpers
  // --------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      error_count++;
    end
  endtask

  // Prints the closing line and ends the simulation
  task automatic end_run();
    $display("Run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // Every task below starts and ends 1 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wb_write(input logic [wb_addr_width-1:0] addr,
                          input logic [wb_data_width-1:0] data);
    int waited;
    waited = 0;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = 1'b1;
    adr    = addr;
    dat_i  = data;
    @(negedge clk);
    while (!ack) begin
      waited++;
      if (waited > wb_timeout) begin
        $display("Wishbone write to address 0x%h never got an ack", addr);
        error_count++;
        end_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    // The strobe was still held at this edge, so a second ack must not follow
    check_value("ack", 32'(ack), 32'h0);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    // Mirror the register map in the model
    if (addr == reg_ctrl_addr) begin
      model_inject = data[1];
    end else if (addr == reg_words_addr) begin
      accepted_count = 0;
    end else if (addr == reg_errors_addr) begin
      injected_count = 0;
    end
  endtask

  task automatic wb_read(input logic [wb_addr_width-1:0] addr,
                         output logic [wb_data_width-1:0] data);
    int waited;
    waited = 0;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = 1'b0;
    adr    = addr;
    @(negedge clk);
    while (!ack) begin
      waited++;
      if (waited > wb_timeout) begin
        $display("Wishbone read from address 0x%h never got an ack", addr);
        error_count++;
        end_run();
      end
      @(negedge clk);
    end
    // Read data is valid while ack is high
    data = dat_o;
    @(posedge clk);
    #1;
    check_value("ack", 32'(ack), 32'h0);
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  // Leaves in_valid low, so a following call makes the words back-to-back
  task automatic send_word(input logic [link_data_width-1:0] data);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_data  = data;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > in_timeout) begin
        $display("Input word was never accepted, in_ready stayed low");
        error_count++;
        end_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0) begin
      waited++;
      if (waited > drain_timeout) begin
        $display("Words in flight never arrived at the output");
        error_count++;
        end_run();
      end
      @(posedge clk);
      #1;
    end
    // A few quiet cycles catch any extra output words
    idle_cycles(3);
  endtask

  // --------------------------------------
  // Monitor and reference model
  // --------------------------------------

  // Everything is sampled on the falling edge where DUT signals are stable
  initial begin
    expect_t head;
    expect_t entry;
    forever begin
      @(negedge clk);
      cycle++;
      if (out_valid) begin
        if (expect_q.size() == 0) begin
          $display("out_valid was high at cycle %0d with no word expected", cycle);
          error_count++;
        end else begin
          head = expect_q.pop_front();
          check_value("out_data", out_data, head.data);
          check_value("out_cycle", cycle, head.cycle + link_latency);
          // The error counter moves on the same edge that raises out_valid
          if (head.inject) begin
            injected_count++;
          end
        end
      end
      // The word is taken at the next rising edge, which this count names
      if (in_valid && in_ready) begin
        entry.data   = in_data;
        entry.cycle  = cycle + 1;
        entry.inject = model_inject;
        expect_q.push_back(entry);
        accepted_count++;
      end
    end
  end

  // --------------------------------------
  // Test sequence
  // --------------------------------------

  initial begin
    logic [wb_data_width-1:0] rd;
    int                       gap;
    void'($urandom(32'h3ab9_e909));
    rst_n    = 1'b0;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_i    = '0;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle state after reset
    check_value("out_valid", 32'(out_valid), 32'h0);
    check_value("in_ready", 32'(in_ready), 32'h0);
    wb_read(reg_ctrl_addr, rd);
    check_value("reg_ctrl", rd, 32'h0);
    wb_read(reg_words_addr, rd);
    check_value("reg_words", rd, 32'h0);
    wb_read(reg_errors_addr, rd);
    check_value("reg_errors", rd, 32'h0);

    // Random burst, a gap of 0 or 1 gives back-to-back words
    wb_write(reg_ctrl_addr, 32'h1);
    check_value("in_ready", 32'(in_ready), 32'h1);
    for (int i = 0; i < 40; i++) begin
      send_word($urandom);
      gap = int'($urandom % 4);
      if (gap > 1) begin
        idle_cycles(gap - 1);
      end
    end
    wait_drain();
    wb_read(reg_words_addr, rd);
    check_value("reg_words", rd, 32'(accepted_count));
    wb_read(reg_errors_addr, rd);
    check_value("reg_errors", rd, 32'h0);

    // Injected parity errors on a random subset of words
    for (int i = 0; i < 30; i++) begin
      if ($urandom % 2 == 0) begin
        wb_write(reg_ctrl_addr, ($urandom % 2 == 0) ? 32'h3 : 32'h1);
      end
      send_word($urandom);
      idle_cycles(int'($urandom % 3));
    end
    wait_drain();
    wb_read(reg_errors_addr, rd);
    check_value("reg_errors", rd, 32'(injected_count));
    wb_read(reg_words_addr, rd);
    check_value("reg_words", rd, 32'(accepted_count));

    // Clear both counters, then count again from zero
    wb_write(reg_ctrl_addr, 32'h1);
    wb_write(reg_words_addr, 32'h0);
    wb_write(reg_errors_addr, 32'h0);
    wb_read(reg_words_addr, rd);
    check_value("reg_words", rd, 32'h0);
    wb_read(reg_errors_addr, rd);
    check_value("reg_errors", rd, 32'h0);
    for (int i = 0; i < 6; i++) begin
      send_word($urandom);
      idle_cycles(int'($urandom % 3));
    end
    wait_drain();
    wb_read(reg_words_addr, rd);
    check_value("reg_words", rd, 32'(accepted_count));

    // Disable with words in flight, which must still arrive
    send_word($urandom);
    send_word($urandom);
    send_word($urandom);
    wb_write(reg_ctrl_addr, 32'h0);
    check_value("in_ready", 32'(in_ready), 32'h0);
    // A waiting source is not accepted while disabled
    in_valid = 1'b1;
    in_data  = $urandom;
    idle_cycles(4);
    in_valid = 1'b0;
    wait_drain();
    wb_read(reg_words_addr, rd);
    check_value("reg_words", rd, 32'(accepted_count));
    wb_read(reg_ctrl_addr, rd);
    check_value("reg_ctrl", rd, 32'h0);

    end_run();
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/link_pkg.sv
source/link_regs.sv
source/link_tx.sv
source/link_delay_valid_next.sv
source/link_rx.sv
source/link_top.sv
bench/link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the link testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module link_tb -f build.f -o link_sim \
  && ./obj_dir/link_sim | tee sim.log \
  && grep -q "^Everything OK$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass, see sim.log"; exit 1; }
